/* rvExecPkg.sv */
// Execute unit datapath types, divider step count and operation latencies
package rvExecPkg;

   typedef logic [31:0] xlenT;       // One RV32 data word
   typedef logic [7:0]  funct3HotT;  // funct3 decoded one-hot, bit n set when funct3 == n
   typedef logic [5:0]  divCountT;   // Holds 0 to 32

   // One quotient bit per step
   parameter divCountT divSteps = 6'd32;

   // Edges from the edge that samples start to the edge that raises done
   parameter int latencySimple = 2;  // ALU, multiply, branch
   parameter int latencyDivide = 35; // Issue, load, 32 steps, result

endpackage

/* rvExecUnit.sv */
// RV32IM execute unit top: issue stage, ALU, multiply/divide unit and result stage
`timescale 1ns/10ps

module rvExecUnit (
   input  logic             clk,
   input  logic             reset,
   input  logic             start,
   input  rvIsaPkg::instrU  instr,
   input  rvExecPkg::xlenT  rs1,
   input  rvExecPkg::xlenT  rs2,
   output logic             busy,
   output logic             done,
   output rvExecPkg::xlenT  result,
   output logic             branchTaken
);

   rvExecPkg::xlenT      op1;
   rvExecPkg::xlenT      op2;
   rvExecPkg::funct3HotT funct3Hot;
   logic                 subtract;
   logic                 arithShift;
   logic                 isMulDiv;
   logic                 isBranch;
   logic                 isSigned1;
   logic                 isSigned2;
   logic                 divStart;
   logic                 issueValid;
   rvExecPkg::xlenT      aluOut;
   logic                 predicate;
   rvExecPkg::xlenT      mulOut;
   rvExecPkg::xlenT      divResult;
   logic                 divDone;

   rvIssueStage issue_i (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .instr      (instr),
      .rs1        (rs1),
      .rs2        (rs2),
      .busy       (busy),
      .op1        (op1),
      .op2        (op2),
      .funct3Hot  (funct3Hot),
      .subtract   (subtract),
      .arithShift (arithShift),
      .isMulDiv   (isMulDiv),
      .isBranch   (isBranch),
      .isSigned1  (isSigned1),
      .isSigned2  (isSigned2),
      .divStart   (divStart),
      .issueValid (issueValid)
   );

   rvIntAlu alu_i (
      .op1        (op1),
      .op2        (op2),
      .funct3Hot  (funct3Hot),
      .subtract   (subtract),
      .arithShift (arithShift),
      .aluOut     (aluOut),
      .predicate  (predicate)
   );

   rvMulDiv mulDiv_i (
      .clk        (clk),
      .reset      (reset),
      .op1        (op1),
      .op2        (op2),
      .funct3Hot  (funct3Hot),
      .isSigned1  (isSigned1),
      .isSigned2  (isSigned2),
      .divStart   (divStart),
      .mulOut     (mulOut),
      .divResult  (divResult),
      .divDone    (divDone)
   );

   rvResultStage result_i (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .issueValid  (issueValid),
      .divDone     (divDone),
      .isMulDiv    (isMulDiv),
      .isBranch    (isBranch),
      .aluOut      (aluOut),
      .mulOut      (mulOut),
      .divResult   (divResult),
      .predicate   (predicate),
      .result      (result),
      .branchTaken (branchTaken),
      .done        (done),
      .busy        (busy)
   );

endmodule

/* rvExecUnit_assertions.sv */
// Protocol checks for the execute unit: start only when idle, done width and done latency
`timescale 1ns/10ps

module rvExecUnitAssertions (
   input logic            clk,
   input logic            reset,
   input logic            start,
   input rvIsaPkg::instrU instr,
   input logic            busy,
   input logic            done
);

   int   errorCount = 0;   // Failed assertion count
   logic isDivide;

   // DIV, DIVU, REM and REMU take the long path through the divider
   assign isDivide = (instr.r.opcode == rvIsaPkg::opOp) &
                     (instr.r.funct7 == rvIsaPkg::funct7MulDiv) & instr.r.funct3[2];

   property doneOneCycle;
      @(posedge clk) disable iff (!reset) done |=> !done;
   endproperty

   property startWhenIdle;
      @(posedge clk) disable iff (!reset) start |-> !busy;
   endproperty

   property simpleLatency;
      @(posedge clk) disable iff (!reset)
         (start && !busy && !isDivide) |->
            ##1 (!done)[*(rvExecPkg::latencySimple - 1)] ##1 done;
   endproperty

   property divideLatency;
      @(posedge clk) disable iff (!reset)
         (start && !busy && isDivide) |->
            ##1 (!done)[*(rvExecPkg::latencyDivide - 1)] ##1 done;
   endproperty

   assert property (doneOneCycle) else begin
      $error("done stayed high longer than one cycle");
      errorCount++;
   end

   assert property (startWhenIdle) else begin
      $error("start arrived while the unit was busy");
      errorCount++;
   end

   assert property (simpleLatency) else begin
      $error("done missed the simple operation latency");
      errorCount++;
   end

   assert property (divideLatency) else begin
      $error("done missed the divide latency");
      errorCount++;
   end

endmodule

/* rvExecUnit_tb.sv */
// Testbench for the execute unit: seeded random ALU, multiply, divide and branch operations
`timescale 1ns/10ps

module rvExecUnit_tb;

   localparam int numOps      = 150 + 80 + 80 + 90;  // ALU, multiply, divide, branch
   localparam int maxOpCycles = 40;                   // Divide takes 36 including the gap
   localparam int timeoutCycles = numOps * maxOpCycles;

   logic            clk;
   logic            reset;
   logic            start;
   rvIsaPkg::instrU instr;
   rvExecPkg::xlenT rs1;
   rvExecPkg::xlenT rs2;
   logic            busy;
   logic            done;
   rvExecPkg::xlenT result;
   logic            branchTaken;
   integer          seed;
   int              cycleCount = 0;

   rvExecUnit rvExecUnit_i (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .instr       (instr),
      .rs1         (rs1),
      .rs2         (rs2),
      .busy        (busy),
      .done        (done),
      .result      (result),
      .branchTaken (branchTaken)
   );

   bind rvExecUnit rvExecUnitAssertions assertions_i (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .instr (instr),
      .busy  (busy),
      .done  (done)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   task automatic abortRun();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= timeoutCycles) begin
         $display("Run timed out after %0d cycles, an operation never finished", cycleCount);
         abortRun();
      end
   end

   task automatic checkResult(input string name, input rvExecPkg::xlenT expected,
                              input rvExecPkg::xlenT actual);
      if (actual !== expected) begin
         $display("FAIL %s result expected %h actual %h", name, expected, actual);
         abortRun();
      end
   endtask

   task automatic checkBranch(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("FAIL %s branchTaken expected %b actual %b", name, expected, actual);
         abortRun();
      end
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("FAIL %s expected %b actual %b", name, expected, actual);
         abortRun();
      end
   endtask

   // Reference model built from the RV32IM instruction definitions
   function automatic rvExecPkg::xlenT expectResult(input rvIsaPkg::instrU ins,
                                                   input rvExecPkg::xlenT a,
                                                   input rvExecPkg::xlenT b);
      rvExecPkg::xlenT opnd;
      longint          sa;
      longint          sb;
      longint          ua;
      longint          ub;
      logic [63:0]     p;
      logic            isOp;
      logic            alt;
      sa   = $signed(a);
      sb   = $signed(b);
      ua   = a;            // Zero extended
      ub   = b;
      isOp = (ins.r.opcode == rvIsaPkg::opOp);
      alt  = ins.r.funct7[5];
      if (ins.r.opcode == rvIsaPkg::opBranch) begin
         return '0;
      end
      if (isOp && ins.r.funct7 == rvIsaPkg::funct7MulDiv) begin
         case (ins.r.funct3)
            3'd0, 3'd1: p = sa * sb;
            3'd2:       p = sa * ub;    // MULHSU
            3'd3:       p = ua * ub;
            3'd4: return (b == 0) ? -64'sd1 : sa / sb;   // Overflow wraps to the dividend
            3'd5: return (b == 0) ? '1 : a / b;
            3'd6: return (b == 0) ? sa : sa % sb;        // Overflow leaves zero
            default: return (b == 0) ? a : a % b;
         endcase
         return (ins.r.funct3 == 3'd0) ? p[31:0] : p[63:32];
      end
      opnd = (ins.r.opcode == rvIsaPkg::opOpImm) ? {{20{ins.i.imm12[11]}}, ins.i.imm12} : b;
      case (ins.r.funct3)
         rvIsaPkg::f3Add:  return (isOp && alt) ? a - opnd : a + opnd;
         rvIsaPkg::f3Sll:  return a << opnd[4:0];
         rvIsaPkg::f3Slt:  return {31'd0, $signed(a) < $signed(opnd)};
         rvIsaPkg::f3Sltu: return {31'd0, a < opnd};
         rvIsaPkg::f3Xor:  return a ^ opnd;
         rvIsaPkg::f3Sr:   return alt ? sa >>> opnd[4:0] : ua >> opnd[4:0];
         rvIsaPkg::f3Or:   return a | opnd;
         default:          return a & opnd;
      endcase
   endfunction

   function automatic logic expectBranch(input logic [2:0] f3, input rvExecPkg::xlenT a,
                                         input rvExecPkg::xlenT b);
      case (f3)
         rvIsaPkg::f3Beq:  return a == b;
         rvIsaPkg::f3Bne:  return a != b;
         rvIsaPkg::f3Blt:  return $signed(a) < $signed(b);
         rvIsaPkg::f3Bge:  return $signed(a) >= $signed(b);
         rvIsaPkg::f3Bltu: return a < b;
         rvIsaPkg::f3Bgeu: return a >= b;
         default:          return 1'b0;
      endcase
   endfunction

   // Sign-bit corners half the time
   function automatic rvExecPkg::xlenT biasedOperand();
      case ($random(seed) & 7)
         0:       return 32'h8000_0000;
         1:       return 32'hffff_ffff;
         2:       return 32'h7fff_ffff;
         3:       return 32'd1;
         default: return $random(seed);
      endcase
   endfunction

   // Entered and left 1 ns after a rising edge
   task automatic runAndCheck(input string kind, input int n, input rvIsaPkg::instrU ins,
                              input rvExecPkg::xlenT a, input rvExecPkg::xlenT b);
      string           name;
      rvExecPkg::xlenT res;
      logic            taken;
      logic            expTaken;
      name  = $sformatf("%s %0d instr %h rs1 %h rs2 %h", kind, n, ins, a, b);
      instr = ins;
      rs1   = a;
      rs2   = b;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      while (done !== 1'b1) begin
         if (busy !== 1'b1) begin
            $display("busy went low before done in %s", name);
            abortRun();
         end
         @(posedge clk);
         #1;
      end
      checkFlag({name, " busy with done"}, 1'b1, busy);
      res      = result;
      taken    = branchTaken;
      expTaken = (ins.r.opcode == rvIsaPkg::opBranch) ?
                 expectBranch(ins.r.funct3, a, b) : 1'b0;
      checkResult(name, expectResult(ins, a, b), res);
      checkBranch(name, expTaken, taken);
      @(posedge clk);
      #1;
      checkFlag({name, " busy after done"}, 1'b0, busy);   // Ready for the next start
   endtask

   initial begin
      rvIsaPkg::instrU ins;
      rvExecPkg::xlenT a;
      rvExecPkg::xlenT b;
      int              pick;
      logic [2:0]      branchF3 [0:5];
      branchF3 = '{rvIsaPkg::f3Beq, rvIsaPkg::f3Bne, rvIsaPkg::f3Blt,
                   rvIsaPkg::f3Bge, rvIsaPkg::f3Bltu, rvIsaPkg::f3Bgeu};
      seed  = 32'ha8d943e1;
      reset = 1'b0;
      start = 1'b0;
      instr = '0;
      rs1   = '0;
      rs2   = '0;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b1;
      checkFlag("reset busy", 1'b0, busy);
      checkFlag("reset done", 1'b0, done);
      checkBranch("reset", 1'b0, branchTaken);
      checkResult("reset", '0, result);

      for (int n = 0; n < 150; n++) begin
         ins = $random(seed);
         ins.r.opcode = ($random(seed) & 1) ? rvIsaPkg::opOp : rvIsaPkg::opOpImm;
         pick = $random(seed) & 1;
         if (ins.r.funct3 == rvIsaPkg::f3Sr ||
             (ins.r.funct3 == rvIsaPkg::f3Add && ins.r.opcode == rvIsaPkg::opOp)) begin
            ins.r.funct7 = pick ? rvIsaPkg::funct7Alt : 7'd0;   // SUB, SRA, SRAI
         end else if (ins.r.opcode == rvIsaPkg::opOp || ins.r.funct3 == rvIsaPkg::f3Sll) begin
            ins.r.funct7 = 7'd0;
         end
         runAndCheck("alu", n, ins, $random(seed), $random(seed));
      end

      for (int n = 0; n < 80; n++) begin
         ins = $random(seed);
         ins.r.opcode = rvIsaPkg::opOp;
         ins.r.funct7 = rvIsaPkg::funct7MulDiv;
         ins.r.funct3 = {1'b0, 2'($random(seed))};
         runAndCheck("mul", n, ins, biasedOperand(), biasedOperand());
      end

      for (int n = 0; n < 80; n++) begin
         ins = $random(seed);
         ins.r.opcode = rvIsaPkg::opOp;
         ins.r.funct7 = rvIsaPkg::funct7MulDiv;
         ins.r.funct3 = {1'b1, 2'($random(seed))};
         pick = $random(seed) & 7;
         a = biasedOperand();
         b = $random(seed);
         b = b >> ($random(seed) & 31);                  // Spread the quotient sizes
         if ($random(seed) & 1) begin
            b = -b;
         end
         if (pick == 0) begin
            b = '0;                                      // Divide by zero
         end else if (pick == 1) begin
            a = 32'h8000_0000;                           // Signed overflow
            b = 32'hffff_ffff;
         end
         runAndCheck("div", n, ins, a, b);
      end

      for (int n = 0; n < 90; n++) begin
         ins = $random(seed);
         ins.r.opcode = rvIsaPkg::opBranch;
         ins.r.funct3 = branchF3[$unsigned($random(seed)) % 6];
         a = biasedOperand();
         b = (($random(seed) & 3) == 0) ? a : biasedOperand();   // Equal operands now and then
         runAndCheck("branch", n, ins, a, b);
      end

      if (rvExecUnit_i.assertions_i.errorCount != 0) begin
         $display("%0d protocol assertions failed", rvExecUnit_i.assertions_i.errorCount);
         abortRun();
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

/* rvIntAlu.sv */
// Integer ALU: add/subtract, compares, shared barrel shifter, logic ops and branch predicate
`timescale 1ns/10ps

module rvIntAlu (
   input  rvExecPkg::xlenT       op1,
   input  rvExecPkg::xlenT       op2,
   input  rvExecPkg::funct3HotT  funct3Hot,
   input  logic                  subtract,
   input  logic                  arithShift,
   output rvExecPkg::xlenT       aluOut,
   output logic                  predicate
);

   rvExecPkg::xlenT    aluPlus;
   logic [32:0]        aluMinus;     // Bit 32 is the borrow
   logic               lt;
   logic               ltu;
   logic               eq;
   rvExecPkg::xlenT    shifterIn;
   logic               shiftFill;
   logic signed [32:0] shiftWide;
   rvExecPkg::xlenT    shiftRight;
   rvExecPkg::xlenT    shiftLeft;
   rvExecPkg::xlenT    addSub;

   function automatic rvExecPkg::xlenT flip32(input rvExecPkg::xlenT x);
      rvExecPkg::xlenT y;
      for (int k = 0; k < 32; k++) begin
         y[k] = x[31-k];
      end
      return y;
   endfunction

   assign aluPlus  = op1 + op2;
   assign aluMinus = {1'b0, op1} - {1'b0, op2};   // One subtract for SUB and all compares

   assign ltu = aluMinus[32];
   assign lt  = (op1[31] ^ op2[31]) ? op1[31] : aluMinus[32];  // Signs differ, negative wins
   assign eq  = (aluMinus[31:0] == 32'd0);

   // Left shift is a right shift of the reversed word
   assign shifterIn  = funct3Hot[rvIsaPkg::f3Sll] ? flip32(op1) : op1;
   assign shiftFill  = arithShift & funct3Hot[rvIsaPkg::f3Sr] & op1[31];
   assign shiftWide  = $signed({shiftFill, shifterIn}) >>> op2[4:0];
   assign shiftRight = shiftWide[31:0];
   assign shiftLeft  = flip32(shiftRight);

   assign addSub = subtract ? aluMinus[31:0] : aluPlus;

   // funct3Hot is one-hot, so the gated terms can simply be ORed
   assign aluOut =
      ({32{funct3Hot[rvIsaPkg::f3Add]}}  & addSub)          |
      ({32{funct3Hot[rvIsaPkg::f3Sll]}}  & shiftLeft)       |
      ({32{funct3Hot[rvIsaPkg::f3Slt]}}  & {31'd0, lt})     |
      ({32{funct3Hot[rvIsaPkg::f3Sltu]}} & {31'd0, ltu})    |
      ({32{funct3Hot[rvIsaPkg::f3Xor]}}  & (op1 ^ op2))     |
      ({32{funct3Hot[rvIsaPkg::f3Sr]}}   & shiftRight)      |
      ({32{funct3Hot[rvIsaPkg::f3Or]}}   & (op1 | op2))     |
      ({32{funct3Hot[rvIsaPkg::f3And]}}  & (op1 & op2));

   // Branch condition, reserved funct3 2 and 3 never taken
   assign predicate =
      (funct3Hot[rvIsaPkg::f3Beq]  &  eq)  |
      (funct3Hot[rvIsaPkg::f3Bne]  & ~eq)  |
      (funct3Hot[rvIsaPkg::f3Blt]  &  lt)  |
      (funct3Hot[rvIsaPkg::f3Bge]  & ~lt)  |
      (funct3Hot[rvIsaPkg::f3Bltu] &  ltu) |
      (funct3Hot[rvIsaPkg::f3Bgeu] & ~ltu);

endmodule

/* rvIsaPkg.sv */
// RV32 instruction encoding: opcodes, funct fields and a two-view instruction word
package rvIsaPkg;

   typedef logic [6:0] opcodeT;            // Major opcode field, bits 6:0

   // The three major opcodes handled by the execute unit
   parameter opcodeT opOpImm  = 7'b0010011; // ALU with I-immediate
   parameter opcodeT opOp     = 7'b0110011; // ALU register-register, also RV32M
   parameter opcodeT opBranch = 7'b1100011; // Conditional branches

   // funct7 patterns, only one bit of each is meaningful
   parameter logic [6:0] funct7MulDiv = 7'b0000001; // Bit 25 selects the M extension
   parameter logic [6:0] funct7Alt    = 7'b0100000; // Bit 30 selects SUB and SRA

   // funct3 for OP and OP-IMM
   parameter logic [2:0] f3Add  = 3'd0;
   parameter logic [2:0] f3Sll  = 3'd1;
   parameter logic [2:0] f3Slt  = 3'd2;
   parameter logic [2:0] f3Sltu = 3'd3;
   parameter logic [2:0] f3Xor  = 3'd4;
   parameter logic [2:0] f3Sr   = 3'd5; // SRL or SRA, told apart by funct7
   parameter logic [2:0] f3Or   = 3'd6;
   parameter logic [2:0] f3And  = 3'd7;

   // funct3 for BRANCH, values 2 and 3 are reserved
   parameter logic [2:0] f3Beq  = 3'd0;
   parameter logic [2:0] f3Bne  = 3'd1;
   parameter logic [2:0] f3Blt  = 3'd4;
   parameter logic [2:0] f3Bge  = 3'd5;
   parameter logic [2:0] f3Bltu = 3'd6;
   parameter logic [2:0] f3Bgeu = 3'd7;

   // One 32-bit word seen as R-type or as I-type
   typedef union packed {
      struct packed {
         logic [6:0] funct7;   // Bits 31:25
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         opcodeT     opcode;
      } r;
      struct packed {
         logic [11:0] imm12;   // Sign extended by the consumer
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         opcodeT      opcode;
      } i;
   } instrU;

endpackage

/* rvIssueStage.sv */
// Issue stage: latches instruction and operands on start and decodes the operation
`timescale 1ns/10ps

module rvIssueStage (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  start,
   input  rvIsaPkg::instrU       instr,
   input  rvExecPkg::xlenT       rs1,
   input  rvExecPkg::xlenT       rs2,
   input  logic                  busy,
   output rvExecPkg::xlenT       op1,
   output rvExecPkg::xlenT       op2,
   output rvExecPkg::funct3HotT  funct3Hot,
   output logic                  subtract,
   output logic                  arithShift,
   output logic                  isMulDiv,
   output logic                  isBranch,
   output logic                  isSigned1,
   output logic                  isSigned2,
   output logic                  divStart,
   output logic                  issueValid
);

   rvIsaPkg::instrU      instrQ;     // Instruction held for the whole operation
   rvExecPkg::xlenT      rs1Q;
   rvExecPkg::xlenT      rs2Q;
   rvExecPkg::xlenT      immI;       // Sign-extended I immediate
   rvExecPkg::funct3HotT hot;
   logic                 issued;     // One cycle after an accepted start
   logic                 isOp;
   logic                 isOpImm;
   logic                 isDivide;
   logic                 altBit;     // Instruction bit 30

   // Issue pulse
   always_ff @(posedge clk) begin
      if (!reset) begin
         issued <= 1'b0;
      end else begin
         issued <= start & ~busy;    // A start while busy is dropped
      end
   end

   always_ff @(posedge clk) begin
      if (start && !busy) begin
         instrQ <= instr;
         rs1Q   <= rs1;
         rs2Q   <= rs2;
      end
   end

   assign isOp     = (instrQ.r.opcode == rvIsaPkg::opOp);
   assign isOpImm  = (instrQ.i.opcode == rvIsaPkg::opOpImm);
   assign isBranch = (instrQ.r.opcode == rvIsaPkg::opBranch);

   assign immI = {{20{instrQ.i.imm12[11]}}, instrQ.i.imm12};

   assign op1 = rs1Q;
   assign op2 = isOpImm ? immI : rs2Q;   // OP and BRANCH compare or combine rs2

   assign hot       = rvExecPkg::funct3HotT'(1) << instrQ.r.funct3;
   assign funct3Hot = hot;

   // Bit 30 is also an immediate bit for ADDI, so SUB needs the OP opcode
   assign altBit     = |(instrQ.r.funct7 & rvIsaPkg::funct7Alt);
   assign subtract   = isOp & altBit;
   assign arithShift = altBit;           // SRA and SRAI

   assign isMulDiv = isOp & |(instrQ.r.funct7 & rvIsaPkg::funct7MulDiv);
   assign isDivide = isMulDiv & instrQ.r.funct3[2];  // funct3 4 to 7

   // MULH signs both operands, MULHSU only the first
   assign isSigned1 = hot[1] | hot[2];
   assign isSigned2 = hot[1];

   assign divStart   = issued & isDivide;   // Divider takes over
   assign issueValid = issued & ~isDivide;  // Result ready next edge

endmodule

/* rvMulDiv.sv */
// RV32M unit: single-cycle 33x33 multiply and 32-step restoring divider with sign fix-up
`timescale 1ns/10ps

module rvMulDiv (
   input  logic                  clk,
   input  logic                  reset,
   input  rvExecPkg::xlenT       op1,
   input  rvExecPkg::xlenT       op2,
   input  rvExecPkg::funct3HotT  funct3Hot,
   input  logic                  isSigned1,
   input  logic                  isSigned2,
   input  logic                  divStart,
   output rvExecPkg::xlenT       mulOut,
   output rvExecPkg::xlenT       divResult,
   output logic                  divDone
);

   logic signed [32:0]  mulA;
   logic signed [32:0]  mulB;
   logic signed [65:0]  product;

   rvExecPkg::xlenT     dividend;      // Partial remainder
   logic [62:0]         divisor;       // Shifted right one place per step
   rvExecPkg::xlenT     quotient;
   rvExecPkg::xlenT     quotientMask;  // Quotient bit set by the current step
   rvExecPkg::divCountT divCount;
   logic                divRunning;
   logic                divStepEn;
   logic                stepDo;
   logic                divUnsigned;
   logic                divIsRem;
   logic                divNegate;
   rvExecPkg::xlenT     mag1;
   rvExecPkg::xlenT     mag2;
   rvExecPkg::xlenT     divRaw;

   // Extra top bit gives unsigned operands a positive sign
   assign mulA    = {isSigned1 & op1[31], op1};
   assign mulB    = {isSigned2 & op2[31], op2};
   assign product = mulA * mulB;
   assign mulOut  = funct3Hot[0] ? product[31:0] : product[63:32];  // MUL low, MULH* high

   // funct3 4 DIV, 5 DIVU, 6 REM, 7 REMU
   assign divUnsigned = funct3Hot[5] | funct3Hot[7];
   assign divIsRem    = funct3Hot[6] | funct3Hot[7];

   assign mag1 = (~divUnsigned & op1[31]) ? -op1 : op1;
   assign mag2 = (~divUnsigned & op2[31]) ? -op2 : op2;

   assign divStepEn = divRunning & (divCount != '0);
   assign divDone   = divRunning & (divCount == '0);
   assign stepDo    = (divisor <= {31'd0, dividend});

   // Step counter and run flag
   always_ff @(posedge clk) begin
      if (!reset) begin
         divRunning <= 1'b0;
         divCount   <= '0;
      end else if (divStart) begin
         divRunning <= 1'b1;
         divCount   <= rvExecPkg::divSteps;
      end else if (divDone) begin
         divRunning <= 1'b0;                 // Result taken this edge
      end else if (divRunning) begin
         divCount <= divCount - 6'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (divStart) begin
         dividend     <= mag1;
         divisor      <= {mag2, 31'd0};
         quotient     <= '0;
         quotientMask <= 32'h8000_0000;     // MSB first
      end else if (divStepEn) begin
         if (stepDo) begin
            dividend <= dividend - divisor[31:0];
            quotient <= quotient | quotientMask;
         end
         divisor      <= divisor >> 1;
         quotientMask <= quotientMask >> 1;
      end
   end

   // Quotient negative when signs differ and divisor nonzero, remainder follows dividend
   // Divide by zero leaves all ones and the dividend, overflow wraps to the dividend
   assign divNegate = ~divUnsigned &
                      (divIsRem ? op1[31] : ((op1[31] ^ op2[31]) & |op2));

   assign divRaw    = divIsRem ? dividend : quotient;
   assign divResult = divNegate ? -divRaw : divRaw;

endmodule

/* rvResultStage.sv */
// Result stage: picks the finished word, registers result and branch outcome, drives done and busy
`timescale 1ns/10ps

module rvResultStage (
   input  logic             clk,
   input  logic             reset,
   input  logic             start,
   input  logic             issueValid,
   input  logic             divDone,
   input  logic             isMulDiv,
   input  logic             isBranch,
   input  rvExecPkg::xlenT  aluOut,
   input  rvExecPkg::xlenT  mulOut,
   input  rvExecPkg::xlenT  divResult,
   input  logic             predicate,
   output rvExecPkg::xlenT  result,
   output logic             branchTaken,
   output logic             done,
   output logic             busy
);

   rvExecPkg::xlenT resultNext;
   logic            finish;     // Some unit has its word ready
   logic            accept;

   assign accept = start & ~busy;
   assign finish = issueValid | divDone;

   always_comb begin
      if (divDone) begin
         resultNext = divResult;
      end else if (isBranch) begin
         resultNext = '0;               // Branches write nothing
      end else if (isMulDiv) begin
         resultNext = mulOut;
      end else begin
         resultNext = aluOut;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         result      <= '0;
         branchTaken <= 1'b0;
         done        <= 1'b0;
         busy        <= 1'b0;
      end else begin
         done <= finish;                // Single-cycle pulse
         if (finish) begin
            result      <= resultNext;
            branchTaken <= isBranch & predicate;
         end
         if (accept) begin
            busy <= 1'b1;
         end else if (done) begin
            busy <= 1'b0;               // Drops after the done cycle
         end
      end
   end

endmodule

/* vlog.f */
rvIsaPkg.sv
rvExecPkg.sv
rvIssueStage.sv
rvIntAlu.sv
rvMulDiv.sv
rvResultStage.sv
rvExecUnit.sv
rvExecUnit_assertions.sv
rvExecUnit_tb.sv
